/* project.f */
logic/rvIsaPkg.sv
logic/coreCfgPkg.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/aluShifter.sv
logic/loadStoreUnit.sv
logic/quarkCore.sv
bench/clockGen.sv
bench/busChecker.sv
bench/quarkBench.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = quarkBench
FILELIST = project.f
LOG      = sim.log
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/quarkBench.sv */
// Testbench top for the quark core
// Random program generator, busy-inserting memory model and watchdog
`timescale 1ns/100ps

module quarkBench;

   localparam int          progLen     = 200;        // Random instructions after the preamble
   localparam int          memWords    = 4096;       // 16 KB model, indexed by address bits 13:2
   localparam int          dataBase    = -256;       // Data region below address zero, off x0
   localparam int          timeLimitNs = progLen * 45 * 20;
   localparam logic [31:0] lfsrSeed    = 32'he504;

   logic        clk;
   logic        mem_rstrb;
   logic [31:0] memAddr, memWdata, memRdata;
   logic [3:0]  memWmask;
   logic        memRead, memRbusy, memWbusy;

   logic [31:0] memory [0:memWords-1];
   logic [31:0] lfsrState = lfsrSeed;
   int          genIdx;

   // Bus values sampled mid-cycle, acted on after the next rising edge
   logic        sRead  = 1'b0;
   logic [3:0]  sMask  = 4'b0;
   logic [31:0] sAddr  = '0;
   logic [31:0] sWdata = '0;
   logic [31:0] rAddr  = '0; // Address captured by the last read strobe
   int          rCount = 0;
   int          wCount = 0;

   clockGen clkGen (.clk(clk), .mem_rstrb(mem_rstrb));

   quarkCore dut (
      .clk(clk), .mem_rstrb(mem_rstrb),
      .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask), .memRead(memRead),
      .memRdata(memRdata), .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   busChecker busCheck (
      .clk(clk), .mem_rstrb(mem_rstrb),
      .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask),
      .memRead(memRead), .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] randBits(int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], fb};
         val       = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic logic [31:0] encodeI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encodeS(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
      return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23}; // Base is always x0
   endfunction

   function automatic logic [31:0] encodeB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] encodeJ(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
   endfunction

   // Size-aligned offset into the data region
   function automatic logic [11:0] dataOffset(logic [1:0] size);
      logic [31:0] off;
      off = dataBase + randBits(6) * 4;
      if (size == 2'd0) off = off + randBits(2);
      else if (size == 2'd1) off = off + 2 * randBits(1);
      return off[11:0];
   endfunction

   task automatic emit(logic [31:0] word);
      memory[genIdx]          = word;
      busCheck.refMem[genIdx] = word;
      genIdx++;
   endtask

   task automatic storeResult(logic [4:0] rd);
      emit(encodeS(dataOffset(2'd2), rd, 3'b010)); // SW rd
   endtask

   task automatic genProgram();
      logic [4:0]  rd, rs1, rs2;
      logic [2:0]  f3;
      logic [1:0]  sz;
      logic [11:0] imm;
      for (int i = 0; i < memWords; i++) begin
         memory[i]          = i * 32'h9e3779b9 + 32'h0bad5eed; // Depends on every index bit
         busCheck.refMem[i] = memory[i];
      end
      genIdx = 0;
      for (int r = 1; r < 32; r++) emit(encodeI(12'(randBits(12)), 5'd0, 3'd0, r[4:0], 7'h13));
      for (int n = 0; n < progLen; n++) begin
         rd  = 5'(randBits(5));
         rs1 = 5'(randBits(5));
         rs2 = 5'(randBits(5));
         f3  = 3'(randBits(3));
         sz  = 2'(randBits(2));
         if (sz == 2'd3) sz = 2'd2;
         case (randBits(3))
            0: begin // Register op, bit 30 only on ADD/SUB and SRL/SRA
               emit({1'b0, (f3 == 3'd0 || f3 == 3'd5) & randBits(1) != 0, 5'd0,
                     rs2, rs1, f3, rd, 7'h33});
               storeResult(rd);
            end
            1: begin // Immediate op, shifts keep a legal funct7
               if (f3 == 3'd1) imm = {7'd0, 5'(randBits(5))};
               else if (f3 == 3'd5) imm = {1'b0, 1'(randBits(1)), 5'd0, 5'(randBits(5))};
               else imm = 12'(randBits(12));
               emit(encodeI(imm, rs1, f3, rd, 7'h13));
               storeResult(rd);
            end
            2: begin
               emit({20'(randBits(20)), rd, (randBits(1) != 0) ? 7'h37 : 7'h17}); // LUI/AUIPC
               storeResult(rd);
            end
            3: begin // Unsigned variants only for byte and half
               emit(encodeI(dataOffset(sz), 5'd0, {sz != 2'd2 && randBits(1) != 0, sz}, rd,
                            7'h03));
               storeResult(rd);
            end
            4: emit(encodeS(dataOffset(sz), rs2, {1'b0, sz}));
            5: begin
               if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 ^ 3'b100; // No branch on 2, 3
               emit(encodeB(13'd8, rs2, rs1, f3));
               emit(encodeI(12'd1, rd, 3'd0, rd, 7'h13)); // Skipped when taken
               storeResult(rd);
            end
            6: begin
               emit(encodeJ(21'd8, rd));
               emit(encodeI(12'd1, rd, 3'd0, rd, 7'h13)); // Never executed
               storeResult(rd);
            end
            default: begin
               rs1 = 5'd1 + 5'(randBits(4));
               emit({20'd0, rs1, 7'h17});                      // AUIPC rs1, 0
               emit(encodeI(12'd12, rs1, 3'd0, rd, 7'h67));    // JALR to the store
               emit(encodeI(12'd1, rd, 3'd0, rd, 7'h13));
               storeResult(rd);
            end
         endcase
      end
      emit(encodeJ(21'd0, 5'd0)); // Final jump to itself
   endtask

   always @(negedge clk) begin
      sRead  = memRead;
      sMask  = memWmask;
      sAddr  = memAddr;
      sWdata = memWdata;
   end

   // Memory model, 0 to 3 busy cycles after each access
   always @(posedge clk) begin
      #2;
      if (rCount > 0) rCount--;
      if (wCount > 0) wCount--;
      if (sRead) begin
         rAddr  = sAddr;
         rCount = int'(randBits(2));
      end
      if (sMask != 4'b0) begin
         for (int b = 0; b < 4; b++) begin
            if (sMask[b]) memory[sAddr[13:2]][8*b +: 8] = sWdata[8*b +: 8];
         end
         wCount = int'(randBits(2));
      end
      memRdata = memory[rAddr[13:2]];
      memRbusy = (rCount != 0);
      memWbusy = (wCount != 0);
   end

   initial begin
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      genProgram();
      wait (busCheck.programDone);
      repeat (4) @(posedge clk);
      $display("Run complete: %0d fetches, %0d stores checked, %0d errors",
               busCheck.fetchCount, busCheck.storeCount, busCheck.errorCount);
      if (busCheck.errorCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(timeLimitNs);
      $display("Timeout: the program never reached its final jump");
      $display("Run aborted: %0d fetches, %0d stores checked, %0d errors",
               busCheck.fetchCount, busCheck.storeCount, busCheck.errorCount + 1);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* bench/busChecker.sv */
// Bus checker with an RV32I instruction-set model
// Replays the program and compares fetch, load and store traffic at the core ports
`timescale 1ns/100ps

module busChecker (
   input logic        clk,
   input logic        mem_rstrb,
   input logic [31:0] memAddr,
   input logic [31:0] memWdata,
   input logic [3:0]  memWmask,
   input logic        memRead,
   input logic        memRbusy,
   input logic        memWbusy
);

   localparam int memWords = 4096;

   logic [31:0] refMem [0:memWords-1]; // Filled by the testbench top
   logic [31:0] regs [0:31];
   logic [31:0] pc          = '0;
   logic        pendLoad    = 1'b0;
   logic        pendStore   = 1'b0;
   logic        programDone = 1'b0;
   logic [31:0] expAddr, expData;
   logic [3:0]  expMask;
   int          errorCount = 0;
   int          fetchCount = 0;
   int          storeCount = 0;
   int          cycle      = 0;
   int          lastFetch  = 0;
   int          shiftAmt   = -1; // Amount of the last shift, -1 if none

   initial begin
      for (int i = 0; i < 32; i++) regs[i] = '0;
   end

   task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
         errorCount++;
      end
   endtask

   task automatic reportError(string what);
      $display("ERROR: %s at %0t", what, $time);
      errorCount++;
   endtask

   // Executes one instruction at pc
   task automatic stepModel();
      logic [31:0]        ins, a, b, res, immI, immS, immB, immU, immJ, npc, word, addr;
      logic signed [31:0] sra;
      logic [4:0]         rd;
      logic [2:0]         f3;
      logic               take, wr;
      ins  = refMem[pc[13:2]];
      a    = regs[ins[19:15]];
      b    = regs[ins[24:20]];
      rd   = ins[11:7];
      f3   = ins[14:12];
      immI = {{20{ins[31]}}, ins[31:20]};
      immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      immU = {ins[31:12], 12'b0};
      immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      npc      = pc + 4;
      wr       = 1'b1;
      res      = '0;
      shiftAmt = -1;
      case (ins[6:0])
         7'h37: res = immU;      // LUI
         7'h17: res = pc + immU; // AUIPC
         7'h6f: begin
            res = npc;
            npc = pc + immJ;
            if (ins == 32'h0000006f) programDone = 1'b1; // Jump to itself
         end
         7'h67: begin
            res = npc;
            npc = (a + immI) & ~32'd1;
         end
         7'h63: begin
            wr = 1'b0;
            case (f3)
               3'd0:    take = (a == b);
               3'd1:    take = (a != b);
               3'd4:    take = ($signed(a) < $signed(b));
               3'd5:    take = ($signed(a) >= $signed(b));
               3'd6:    take = (a < b);
               default: take = (a >= b);
            endcase
            if (take) npc = pc + immB;
         end
         7'h03: begin
            addr = (a + immI) & 32'h00ff_ffff; // 24-bit core addresses
            word = refMem[addr[13:2]] >> (8 * addr[1:0]);
            case (f3)
               3'd0:    res = {{24{word[7]}}, word[7:0]};
               3'd1:    res = {{16{word[15]}}, word[15:0]};
               3'd4:    res = {24'b0, word[7:0]};
               3'd5:    res = {16'b0, word[15:0]};
               default: res = word;
            endcase
            pendLoad = 1'b1;
            expAddr  = addr;
         end
         7'h23: begin
            wr      = 1'b0;
            addr    = (a + immS) & 32'h00ff_ffff;
            expMask = (f3[1:0] == 2'd0) ? 4'b0001 << addr[1:0]
                    : (f3[1:0] == 2'd1) ? 4'b0011 << addr[1:0] : 4'b1111;
            expData = b << (8 * addr[1:0]);
            for (int i = 0; i < 4; i++) begin
               if (expMask[i]) refMem[addr[13:2]][8*i +: 8] = expData[8*i +: 8];
            end
            pendStore = 1'b1;
            expAddr   = addr;
         end
         default: begin // Register and immediate ALU ops
            if (!ins[5]) b = immI;
            sra = $signed(a) >>> b[4:0];
            case (f3)
               3'd0:    res = (ins[5] && ins[30]) ? a - b : a + b;
               3'd1:    res = a << b[4:0];
               3'd2:    res = {31'b0, $signed(a) < $signed(b)};
               3'd3:    res = {31'b0, a < b};
               3'd4:    res = a ^ b;
               3'd5:    res = ins[30] ? sra : a >> b[4:0];
               3'd6:    res = a | b;
               default: res = a & b;
            endcase
            if (f3 == 3'd1 || f3 == 3'd5) shiftAmt = int'(b[4:0]);
         end
      endcase
      if (wr && rd != 5'd0) regs[rd] = res;
      pc = npc;
   endtask

   // Port values are stable at the falling edge
   always @(negedge clk) begin
      if (mem_rstrb) begin
         if (memRead || memWmask != 4'b0) reportError("bus active during reset");
      end else begin
         cycle++;
         if (memRead && !pendLoad) begin // Instruction fetch
            if (pendStore) reportError("expected store never happened");
            if (memRbusy || memWbusy) reportError("fetch strobe while memory busy");
            if (shiftAmt >= 0 && cycle - lastFetch < 4 + shiftAmt) begin
               reportError("fetch before the serial shift finished");
            end
            compare("memAddr (fetch)", memAddr, pc);
            lastFetch = cycle;
            fetchCount++;
            if (!programDone) stepModel();
         end else if (memRead) begin
            compare("memAddr (load)", memAddr, expAddr);
            pendLoad = 1'b0;
         end
         if (memWmask != 4'b0) begin
            if (!pendStore) begin
               reportError("write with no store instruction");
            end else begin
               compare("memAddr (store)", memAddr, expAddr);
               compare("memWmask", {28'b0, memWmask}, {28'b0, expMask});
               compare("memWdata", memWdata & {{8{expMask[3]}}, {8{expMask[2]}},
                       {8{expMask[1]}}, {8{expMask[0]}}}, expData & {{8{expMask[3]}},
                       {8{expMask[2]}}, {8{expMask[1]}}, {8{expMask[0]}}});
               storeCount++;
            end
            pendStore = 1'b0;
         end
      end
   end

endmodule

/* bench/clockGen.sv */
// Testbench clock and reset generator
// 20 ns clock, synchronous reset held for the first 10 cycles
`timescale 1ns/100ps

module clockGen (
   output logic clk,
   output logic mem_rstrb
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk; // 20 ns period
   end

   initial begin
      mem_rstrb = 1'b1;
      repeat (10) @(posedge clk);
      #2 mem_rstrb = 1'b0; // Same 2 ns input delay as the bus
   end

endmodule

/* logic/quarkCore.sv */
// Quark RV32I core top
// Control FSM, program counter, write-back selection and the memory bus
`timescale 1ns/100ps

module quarkCore (
   input  logic                      clk,
   input  logic                      mem_rstrb,
   output logic [rvIsaPkg::xlen-1:0] memAddr,
   output logic [rvIsaPkg::xlen-1:0] memWdata,
   output logic [3:0]                memWmask,
   output logic                      memRead,
   input  logic [rvIsaPkg::xlen-1:0] memRdata,
   input  logic                      memRbusy,
   input  logic                      memWbusy
);
   import rvIsaPkg::*;
   import coreCfgPkg::*;

   coreStateT              state;
   logic [addrWidth-1:0]   pc;
   logic [addrWidth-1:0]   pcPlus4;
   logic [xlen-1:0]        pcPlusImm; // Full width, AUIPC needs all 32 bits
   logic [xlen-1:0]        pcImm;

   logic [regIdxWidth-1:0] rdIdx;
   logic [2:0]             funct3;
   logic                   altFunct;
   logic                   isLoad, isStore, isAluImm, isAluReg, isJal;
   logic                   isJalr, isLui, isAuipc, isBranch;
   logic [xlen-1:0]        immI, immS, immB, immU, immJ;

   logic [xlen-1:0]        rs1Val, rs2Val;
   logic [xlen-1:0]        aluOut, aluSum;
   logic                   branchTaken, aluBusy, aluStart;
   logic [addrWidth-1:0]   lsAddr;
   logic [xlen-1:0]        storeData, loadData;
   logic [3:0]             storeMask;

   logic                   instrLoad;
   logic                   isAlu;
   logic                   needToWait;
   logic                   waitDone;
   logic                   writeEn;
   logic [xlen-1:0]        writeData;

   instrDecoder decoder (
      .clk(clk), .instrLoad(instrLoad), .memRdata(memRdata),
      .rdIdx(rdIdx), .funct3(funct3), .altFunct(altFunct),
      .isLoad(isLoad), .isStore(isStore), .isAluImm(isAluImm), .isAluReg(isAluReg),
      .isJal(isJal), .isJalr(isJalr), .isLui(isLui), .isAuipc(isAuipc),
      .isBranch(isBranch),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ)
   );

   registerFile regFile (
      .clk(clk), .instrLoad(instrLoad), .memRdata(memRdata),
      .writeEn(writeEn), .rdIdx(rdIdx), .writeData(writeData),
      .rs1Val(rs1Val), .rs2Val(rs2Val)
   );

   aluShifter alu (
      .clk(clk), .mem_rstrb(mem_rstrb), .aluStart(aluStart),
      .funct3(funct3), .altFunct(altFunct), .useRs2(isAluReg | isBranch),
      .rs1Val(rs1Val), .rs2Val(rs2Val), .immI(immI),
      .aluOut(aluOut), .aluSum(aluSum), .branchTaken(branchTaken), .aluBusy(aluBusy)
   );

   loadStoreUnit lsu (
      .isStore(isStore), .funct3(funct3), .rs1Val(rs1Val), .rs2Val(rs2Val),
      .immI(immI), .immS(immS), .memRdata(memRdata),
      .lsAddr(lsAddr), .storeData(storeData), .storeMask(storeMask), .loadData(loadData)
   );

   assign isAlu      = isAluImm | isAluReg;
   assign needToWait = isLoad | isStore
                     | (isAlu & ((aluFunctT'(funct3) == fnSll) || (aluFunctT'(funct3) == fnSr)));
   assign waitDone   = !aluBusy && !memRbusy && !memWbusy;
   assign instrLoad  = (state == stWaitInstr) && !memRbusy;
   assign aluStart   = (state == stExecute) && isAlu;

   assign pcPlus4   = pc + 3'd4;
   assign pcImm     = isJal ? immJ : isAuipc ? immU : immB; // One adder for all three
   assign pcPlusImm = {{(xlen-addrWidth){1'b0}}, pc} + pcImm;

   // Loads and shifts write on the wait exit, everything else in execute
   assign writeEn = !(isBranch | isStore)
                  & (((state == stExecute) & !needToWait)
                  | ((state == stWaitAluOrMem) & waitDone));

   always_comb begin
      if (isLui)               writeData = immU;
      else if (isAlu)          writeData = aluOut;
      else if (isAuipc)        writeData = pcPlusImm;
      else if (isJal | isJalr) writeData = {{(xlen-addrWidth){1'b0}}, pcPlus4}; // Link
      else                     writeData = loadData;
   end

   // PC during fetch, data address otherwise
   assign memAddr  = {{(xlen-addrWidth){1'b0}},
                      ((state == stFetchInstr) || (state == stWaitInstr)) ? pc : lsAddr};
   assign memWdata = storeData;
   assign memWmask = {4{(state == stExecute) & isStore}} & storeMask;
   assign memRead  = (state == stFetchInstr) || ((state == stExecute) && isLoad);

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         state <= stWaitAluOrMem; // Wait for idle bus before first fetch
         pc    <= resetAddr;
      end else begin
         case (state)
            stFetchInstr: state <= stWaitInstr;
            stWaitInstr: begin
               if (!memRbusy) state <= stExecute;
            end
            stExecute: begin
               if (isJalr)                         pc <= {aluSum[addrWidth-1:1], 1'b0};
               else if (isJal | (isBranch & branchTaken)) pc <= pcPlusImm[addrWidth-1:0];
               else                                pc <= pcPlus4;
               state <= needToWait ? stWaitAluOrMem : stFetchInstr;
            end
            default: begin // stWaitAluOrMem
               if (waitDone) state <= stFetchInstr;
            end
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (mem_rstrb) $onehot(state));

   // A read strobe and a write never share a cycle
   assert property (@(posedge clk) disable iff (mem_rstrb) !(memRead && |memWmask));

endmodule

/* logic/loadStoreUnit.sv */
// Load/store unit
// Address adder, load lane extraction with sign extension, store lanes and write mask
`timescale 1ns/100ps

module loadStoreUnit (
   input  logic                             isStore,
   input  logic [2:0]                       funct3,
   input  logic [rvIsaPkg::xlen-1:0]        rs1Val,
   input  logic [rvIsaPkg::xlen-1:0]        rs2Val,
   input  logic [rvIsaPkg::xlen-1:0]        immI,
   input  logic [rvIsaPkg::xlen-1:0]        immS,
   input  logic [rvIsaPkg::xlen-1:0]        memRdata,
   output logic [coreCfgPkg::addrWidth-1:0] lsAddr,
   output logic [rvIsaPkg::xlen-1:0]        storeData,
   output logic [3:0]                       storeMask,
   output logic [rvIsaPkg::xlen-1:0]        loadData
);
   import rvIsaPkg::*;
   import coreCfgPkg::*;

   accessSizeT           size;
   logic [addrWidth-1:0] offset;
   logic [15:0]          loadHalf;
   logic [7:0]           loadByte;
   logic                 loadSign;

   assign size   = accessSizeT'(funct3[1:0]);
   assign offset = isStore ? immS[addrWidth-1:0] : immI[addrWidth-1:0];
   assign lsAddr = rs1Val[addrWidth-1:0] + offset;

   // Load lane picked by the low address bits
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !funct3[2] & ((size == sizeByte) ? loadByte[7] : loadHalf[15]); // LBU/LHU

   always_comb begin
      case (size)
         sizeByte: loadData = {{24{loadSign}}, loadByte};
         sizeHalf: loadData = {{16{loadSign}}, loadHalf};
         default:  loadData = memRdata;
      endcase
   end

   // Low bytes of rs2 copied into whichever lanes the mask enables
   assign storeData[7:0]   = rs2Val[7:0];
   assign storeData[15:8]  = lsAddr[0] ? rs2Val[7:0] : rs2Val[15:8];
   assign storeData[23:16] = lsAddr[1] ? rs2Val[7:0] : rs2Val[23:16];
   assign storeData[31:24] = lsAddr[0] ? rs2Val[7:0]
                           : lsAddr[1] ? rs2Val[15:8] : rs2Val[31:24];

   always_comb begin
      case (size)
         sizeByte: storeMask = 4'b0001 << lsAddr[1:0];
         sizeHalf: storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
         default:  storeMask = 4'b1111;
      endcase
   end

endmodule

/* logic/aluShifter.sv */
// ALU with serial shifter
// Add/sub, compares, logic ops, one-bit-per-cycle shifts and the branch predicate
`timescale 1ns/100ps

module aluShifter (
   input  logic                      clk,
   input  logic                      mem_rstrb,
   input  logic                      aluStart,
   input  logic [2:0]                funct3,
   input  logic                      altFunct,
   input  logic                      useRs2,
   input  logic [rvIsaPkg::xlen-1:0] rs1Val,
   input  logic [rvIsaPkg::xlen-1:0] rs2Val,
   input  logic [rvIsaPkg::xlen-1:0] immI,
   output logic [rvIsaPkg::xlen-1:0] aluOut,
   output logic [rvIsaPkg::xlen-1:0] aluSum,
   output logic                      branchTaken,
   output logic                      aluBusy
);
   import rvIsaPkg::*;
   import coreCfgPkg::*;

   aluFunctT              fn;
   logic [xlen-1:0]       aluIn1;
   logic [xlen-1:0]       aluIn2;
   logic [xlen:0]         aluMinus; // One extra bit holds the borrow
   logic                  lt;
   logic                  ltu;
   logic                  eq;
   logic                  isShift;
   logic [xlen-1:0]       shiftReg;
   logic [shamtWidth-1:0] shamt;    // Remaining shift steps

   assign fn     = aluFunctT'(funct3);
   assign aluIn1 = rs1Val;
   assign aluIn2 = useRs2 ? rs2Val : immI; // Branches and reg ops use rs2

   assign aluSum   = aluIn1 + aluIn2; // Also the JALR target
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, aluIn1} + 1'b1;

   assign ltu = aluMinus[xlen];
   assign lt  = (aluIn1[xlen-1] ^ aluIn2[xlen-1]) ? aluIn1[xlen-1] : aluMinus[xlen];
   assign eq  = (aluMinus[xlen-1:0] == '0);

   assign isShift = (fn == fnSll) || (fn == fnSr);
   assign aluBusy = |shamt;

   always_comb begin
      case (fn)
         fnAdd:   aluOut = altFunct ? aluMinus[xlen-1:0] : aluSum;
         fnSlt:   aluOut = {{(xlen-1){1'b0}}, lt};
         fnSltu:  aluOut = {{(xlen-1){1'b0}}, ltu};
         fnXor:   aluOut = aluIn1 ^ aluIn2;
         fnOr:    aluOut = aluIn1 | aluIn2;
         fnAnd:   aluOut = aluIn1 & aluIn2;
         default: aluOut = shiftReg; // SLL, SRL, SRA
      endcase
   end

   // Branch funct3 reuses the compare results
   always_comb begin
      case (funct3)
         3'b000:  branchTaken = eq;   // BEQ
         3'b001:  branchTaken = !eq;  // BNE
         3'b100:  branchTaken = lt;   // BLT
         3'b101:  branchTaken = !lt;  // BGE
         3'b110:  branchTaken = ltu;  // BLTU
         3'b111:  branchTaken = !ltu; // BGEU
         default: branchTaken = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         shamt <= '0;
      end else if (aluStart && isShift) begin
         shamt <= aluIn2[shamtWidth-1:0];
      end else if (aluBusy) begin
         shamt <= shamt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (aluStart && isShift) begin
         shiftReg <= aluIn1;
      end else if (aluBusy) begin
         shiftReg <= (fn == fnSll) ? shiftReg << 1
                   : {altFunct & shiftReg[xlen-1], shiftReg[xlen-1:1]}; // SRA fills sign
      end
   end

   // A new operation never starts while a shift is still counting
   assert property (@(posedge clk) disable iff (mem_rstrb)
      aluStart |-> !aluBusy);

endmodule

/* logic/registerFile.sv */
// 32-entry register file
// Source reads happen while the instruction word is on the bus, x0 reads as zero
`timescale 1ns/100ps

module registerFile (
   input  logic                             clk,
   input  logic                             instrLoad,
   input  logic [rvIsaPkg::xlen-1:0]        memRdata,
   input  logic                             writeEn,
   input  logic [rvIsaPkg::regIdxWidth-1:0] rdIdx,
   input  logic [rvIsaPkg::xlen-1:0]        writeData,
   output logic [rvIsaPkg::xlen-1:0]        rs1Val,
   output logic [rvIsaPkg::xlen-1:0]        rs2Val
);
   import rvIsaPkg::*;

   logic [xlen-1:0]        regs [0:2**regIdxWidth-1];
   logic [regIdxWidth-1:0] rs1Idx;
   logic [regIdxWidth-1:0] rs2Idx;

   assign rs1Idx = memRdata[19:15]; // Source fields straight off the bus
   assign rs2Idx = memRdata[24:20];

   always_ff @(posedge clk) begin
      if (writeEn && rdIdx != '0) begin // x0 is never written
         regs[rdIdx] <= writeData;
      end
      if (instrLoad) begin
         rs1Val <= (rs1Idx == '0) ? '0 : regs[rs1Idx];
         rs2Val <= (rs2Idx == '0) ? '0 : regs[rs2Idx];
      end
   end

endmodule

/* logic/instrDecoder.sv */
// Instruction decoder
// Latches the fetched instruction, classifies the opcode and builds the immediates
`timescale 1ns/100ps

module instrDecoder (
   input  logic                          clk,
   input  logic                          instrLoad,
   input  logic [rvIsaPkg::xlen-1:0]     memRdata,
   output logic [rvIsaPkg::regIdxWidth-1:0] rdIdx,
   output logic [2:0]                    funct3,
   output logic                          altFunct,
   output logic                          isLoad,
   output logic                          isStore,
   output logic                          isAluImm,
   output logic                          isAluReg,
   output logic                          isJal,
   output logic                          isJalr,
   output logic                          isLui,
   output logic                          isAuipc,
   output logic                          isBranch,
   output logic [rvIsaPkg::xlen-1:0]     immI,
   output logic [rvIsaPkg::xlen-1:0]     immS,
   output logic [rvIsaPkg::xlen-1:0]     immB,
   output logic [rvIsaPkg::xlen-1:0]     immU,
   output logic [rvIsaPkg::xlen-1:0]     immJ
);
   import rvIsaPkg::*;

   logic [31:2] instr; // Bits 1:0 are always 11 in RV32I
   opcodeT      opcode;

   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instr <= memRdata[31:2];
      end
   end

   assign opcode = opcodeT'(instr[6:2]);

   assign isLoad   = (opcode == opLoad);
   assign isStore  = (opcode == opStore);
   assign isAluImm = (opcode == opAluImm);
   assign isAluReg = (opcode == opAluReg);
   assign isJal    = (opcode == opJal);
   assign isJalr   = (opcode == opJalr);
   assign isLui    = (opcode == opLui);
   assign isAuipc  = (opcode == opAuipc);
   assign isBranch = (opcode == opBranch);

   assign rdIdx  = instr[11:7];
   assign funct3 = instr[14:12];

   // Bit 30 is part of the I immediate, so it only means SUB on register ops
   // but still selects SRA for both SRAI and SRA
   assign altFunct = instr[30] & (isAluReg | (aluFunctT'(instr[14:12]) == fnSr));

   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

/* logic/coreCfgPkg.sv */
// Core microarchitecture constants
// Address width, reset vector, shift counter width and control states
package coreCfgPkg;

   localparam int addrWidth  = 24; // Internal address width
   localparam int shamtWidth = 5;  // Serial shift counter width

   localparam logic [addrWidth-1:0] resetAddr = '0; // First fetch address

   // Control states, one-hot
   typedef enum logic [3:0] {
      stFetchInstr   = 4'b0001,
      stWaitInstr    = 4'b0010,
      stExecute      = 4'b0100,
      stWaitAluOrMem = 4'b1000
   } coreStateT;

endpackage

/* logic/rvIsaPkg.sv */
// RV32I encoding definitions
// Major opcodes, ALU function codes and memory access sizes
package rvIsaPkg;

   localparam int xlen        = 32; // Data word width
   localparam int regIdxWidth = 5;  // Register index width

   // Major opcodes kept by the core, instruction bits 6:2
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011
   } opcodeT;

   // ALU operation in funct3
   typedef enum logic [2:0] {
      fnAdd  = 3'b000, // ADD or SUB
      fnSll  = 3'b001,
      fnSlt  = 3'b010,
      fnSltu = 3'b011,
      fnXor  = 3'b100,
      fnSr   = 3'b101, // SRL or SRA
      fnOr   = 3'b110,
      fnAnd  = 3'b111
   } aluFunctT;

   // Load/store size, funct3 bits 1:0
   typedef enum logic [1:0] {
      sizeByte = 2'b00,
      sizeHalf = 2'b01,
      sizeWord = 2'b10
   } accessSizeT;

endpackage
